// ==== design/bg_map_ram.sv ====
`timescale 1ns/100ps

module bg_map_ram #(
	parameter int DEPTH = 1024
) (
	input  logic                clk_100mhz_buf,
	input  console_pkg::bg_wr_t wr,
	input  console_pkg::index_t rd_addr,
	output console_pkg::byte_t  tile_rd_data,
	output console_pkg::byte_t  attr_rd_data
);

	// Tile numbers per map cell
	console_pkg::byte_t tile_mem [DEPTH];
	// Palette and flip bits per map cell
	console_pkg::byte_t attr_mem [DEPTH];

	////////////////////////////////
	// Writes
	////////////////////////////////

	// Address and data shared, enables not
	always_ff @(posedge clk_100mhz_buf) begin
		if (wr.tile_we) begin
			tile_mem[wr.addr] <= wr.data;
		end
		if (wr.attr_we) begin
			attr_mem[wr.addr] <= wr.data;
		end
	end

	////////////////////////////////
	// Debug reads
	////////////////////////////////

	// Both maps at the same cell, one cycle late
	always_ff @(posedge clk_100mhz_buf) begin
		tile_rd_data <= tile_mem[rd_addr];
		attr_rd_data <= attr_mem[rd_addr];
	end

endmodule

// ==== design/console_pkg.sv ====
package console_pkg;

	////////////////////////////////
	// Basic data types
	////////////////////////////////

	// CPU data word
	typedef logic [31:0] word_t;
	// S-type index field
	typedef logic [9:0] index_t;
	// One map entry or one OAM lane
	typedef logic [7:0] byte_t;
	// Status LEDs
	typedef logic [7:0] led_t;

	// PPU store opcodes, all other codes ignored
	typedef enum logic [3:0] {
		ppu_oam_word = 4'h1,
		ppu_oam_byte = 4'h2,
		ppu_bg_tile  = 4'h3,
		ppu_bg_attr  = 4'h4
	} ppu_op_e;

	// Operand source from the CPU pipeline
	typedef enum logic [1:0] {
		fwd_none     = 2'd0,
		fwd_mem_alu  = 2'd1,
		fwd_wb_alu   = 2'd2,
		fwd_mem_load = 2'd3
	} fwd_sel_e;

	////////////////////////////////
	// Bus bundles
	////////////////////////////////

	// S-type store as issued by the CPU
	typedef struct packed {
		logic     en;
		ppu_op_e  opcode;
		index_t   index;
		word_t    value;
		// Index operand select
		fwd_sel_e fwd_src_in1;
		// Value operand select
		fwd_sel_e fwd_src_in2;
	} cpu_ppu_cmd_t;

	// Pipeline results for forwarding
	typedef struct packed {
		word_t mem_alu;
		word_t wb_alu;
		word_t mem_load;
	} fwd_bus_t;

	// OAM write request, one enable per byte lane
	typedef struct packed {
		logic [3:0] we;
		logic [5:0] addr;
		word_t      data;
	} oam_wr_t;

	// Background write request, shared address and data
	typedef struct packed {
		logic   tile_we;
		logic   attr_we;
		index_t addr;
		byte_t  data;
	} bg_wr_t;

	// Scan position and sync state
	typedef struct packed {
		logic [9:0] x;
		logic [9:0] y;
		logic       hsync;
		logic       vsync;
		logic       blank;
	} scan_pos_t;

endpackage

// ==== design/console_top.sv ====
`timescale 1ns/100ps

module console_top #(
	parameter int PIX_DIV  = 4,
	parameter int H_ACTIVE = 640,
	parameter int H_FRONT  = 16,
	parameter int H_SYNC   = 96,
	parameter int H_BACK   = 48,
	parameter int V_ACTIVE = 480,
	parameter int V_FRONT  = 10,
	parameter int V_SYNC   = 2,
	parameter int V_BACK   = 33
) (
	input  logic                      clk_100mhz_buf,
	input  logic                      rst,
	input  console_pkg::cpu_ppu_cmd_t cmd,
	input  console_pkg::fwd_bus_t     fwd,
	input  logic                      keyboard_intr,
	input  logic [5:0]                oam_rd_addr,
	input  console_pkg::index_t       bg_rd_addr,
	output console_pkg::word_t        oam_rd_data,
	output console_pkg::byte_t        bg_tile_rd_data,
	output console_pkg::byte_t        bg_attr_rd_data,
	output console_pkg::scan_pos_t    scan,
	output logic                      frame_tick,
	output console_pkg::led_t         leds
);

	// Operands after forwarding
	console_pkg::index_t  index_res;
	console_pkg::word_t   value_res;
	// Registered write requests
	console_pkg::oam_wr_t oam_wr;
	console_pkg::bg_wr_t  bg_wr;

	////////////////////////////////
	// Command path
	////////////////////////////////

	// Index from the low bits of a forwarded word
	operand_fwd_mux #(.payload_t(console_pkg::index_t)) index_mux_inst (
		.sel(cmd.fwd_src_in1), .field(cmd.index), .fwd(fwd), .operand(index_res)
	);

	// Full value word
	operand_fwd_mux #(.payload_t(console_pkg::word_t)) value_mux_inst (
		.sel(cmd.fwd_src_in2), .field(cmd.value), .fwd(fwd), .operand(value_res)
	);

	ppu_cmd_ctrl ppu_cmd_ctrl_inst (
		.clk_100mhz_buf(clk_100mhz_buf), .rst(rst), .cmd(cmd),
		.index(index_res), .value(value_res), .oam_wr(oam_wr), .bg_wr(bg_wr)
	);

	////////////////////////////////
	// Memories
	////////////////////////////////

	oam_ram #(.DEPTH(64)) oam_ram_inst (
		.clk_100mhz_buf(clk_100mhz_buf), .wr(oam_wr),
		.rd_addr(oam_rd_addr), .rd_data(oam_rd_data)
	);

	bg_map_ram #(.DEPTH(1024)) bg_map_ram_inst (
		.clk_100mhz_buf(clk_100mhz_buf), .wr(bg_wr), .rd_addr(bg_rd_addr),
		.tile_rd_data(bg_tile_rd_data), .attr_rd_data(bg_attr_rd_data)
	);

	// Timing and status
	scan_timing #(
		.PIX_DIV(PIX_DIV), .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC),
		.H_BACK(H_BACK), .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC),
		.V_BACK(V_BACK)
	) scan_timing_inst (
		.clk_100mhz_buf(clk_100mhz_buf), .rst(rst), .scan(scan)
	);

	frame_tick_status frame_tick_status_inst (
		.clk_100mhz_buf(clk_100mhz_buf), .rst(rst), .scan(scan), .oam_wr(oam_wr),
		.keyboard_intr(keyboard_intr), .frame_tick(frame_tick), .leds(leds)
	);

endmodule

// ==== design/frame_tick_status.sv ====
`timescale 1ns/100ps

module frame_tick_status (
	input  logic                   clk_100mhz_buf,
	input  logic                   rst,
	input  console_pkg::scan_pos_t scan,
	input  console_pkg::oam_wr_t   oam_wr,
	input  logic                   keyboard_intr,
	output logic                   frame_tick,
	output console_pkg::led_t      leds
);

	// Last vsync level, idles high
	logic vsync_q;
	// Reset state one cycle back
	logic rst_q;

	////////////////////////////////
	// Frame tick
	////////////////////////////////

	always_ff @(posedge clk_100mhz_buf) begin
		if (rst) begin
			vsync_q <= 1'b1;
		end else begin
			vsync_q <= scan.vsync;
		end
	end

	// Keeps a stale edge from firing right out of reset
	always_ff @(posedge clk_100mhz_buf) begin
		rst_q <= rst;
	end

	// Falling vsync, masked just after reset
	assign frame_tick = vsync_q & ~scan.vsync & ~rst_q;

	////////////////////////////////
	// Status LEDs
	////////////////////////////////

	always_ff @(posedge clk_100mhz_buf) begin
		if (rst) begin
			leds <= '0;
		end else begin
			// Heartbeat per frame
			if (frame_tick) leds[0] <= ~leds[0];
			// Heartbeat per key
			if (keyboard_intr) leds[1] <= ~leds[1];
			// Last OAM slot touched
			if (|oam_wr.we) leds[7:2] <= oam_wr.addr;
		end
	end

endmodule

// ==== design/oam_ram.sv ====
`timescale 1ns/100ps

module oam_ram #(
	parameter int DEPTH = 64
) (
	input  logic                 clk_100mhz_buf,
	input  console_pkg::oam_wr_t wr,
	input  logic [5:0]           rd_addr,
	output console_pkg::word_t   rd_data
);

	// Sprite attribute words
	console_pkg::word_t mem [DEPTH];

	////////////////////////////////
	// Byte-lane write
	////////////////////////////////

	// Each lane written only under its own enable
	always_ff @(posedge clk_100mhz_buf) begin
		for (int i = 0; i < 4; i++) begin
			if (wr.we[i]) begin
				mem[wr.addr][8*i +: 8] <= wr.data[8*i +: 8];
			end
		end
	end

	////////////////////////////////
	// Debug read
	////////////////////////////////

	// One cycle latency
	// Same-address write in the same cycle gives old data
	always_ff @(posedge clk_100mhz_buf) begin
		rd_data <= mem[rd_addr];
	end

endmodule

// ==== design/operand_fwd_mux.sv ====
`timescale 1ns/100ps

module operand_fwd_mux #(
	parameter type payload_t = console_pkg::word_t
) (
	input  console_pkg::fwd_sel_e sel,
	input  payload_t              field,
	input  console_pkg::fwd_bus_t fwd,
	output payload_t              operand
);

	// Forwarded words cut down to the payload width
	always_comb begin
		case (sel)
			// Pipeline ALU result, MEM stage
			console_pkg::fwd_mem_alu:  operand = payload_t'(fwd.mem_alu);
			// Pipeline ALU result, WB stage
			console_pkg::fwd_wb_alu:   operand = payload_t'(fwd.wb_alu);
			// Load data, MEM stage
			console_pkg::fwd_mem_load: operand = payload_t'(fwd.mem_load);
			// No hazard, command field as is
			default:                   operand = field;
		endcase
	end

endmodule

// ==== design/ppu_cmd_ctrl.sv ====
`timescale 1ns/100ps

module ppu_cmd_ctrl (
	input  logic                      clk_100mhz_buf,
	input  logic                      rst,
	input  console_pkg::cpu_ppu_cmd_t cmd,
	input  console_pkg::index_t       index,
	input  console_pkg::word_t        value,
	output console_pkg::oam_wr_t      oam_wr,
	output console_pkg::bg_wr_t       bg_wr
);

	// Next-cycle write request
	logic [3:0]          oam_we_d;
	console_pkg::word_t  oam_data_d;
	logic                tile_we_d;
	logic                attr_we_d;
	// Byte lane picked by the top index bits
	logic [1:0]          lane;

	// Registered requests
	logic [3:0]          oam_we_q;
	logic [5:0]          oam_addr_q;
	console_pkg::word_t  oam_data_q;
	logic                tile_we_q;
	logic                attr_we_q;
	console_pkg::index_t bg_addr_q;
	console_pkg::byte_t  bg_data_q;

	assign lane = index[9:8];

	////////////////////////////////
	// Opcode decode
	////////////////////////////////

	always_comb begin
		oam_we_d   = 4'b0000;
		oam_data_d = value;
		tile_we_d  = 1'b0;
		attr_we_d  = 1'b0;
		// Nothing happens without the enable
		if (cmd.en) begin
			case (cmd.opcode)
				// Whole word, all lanes
				console_pkg::ppu_oam_word: oam_we_d = 4'b1111;
				console_pkg::ppu_oam_byte: begin
					// One lane, low byte shifted into place
					oam_we_d   = 4'b0001 << lane;
					oam_data_d = console_pkg::word_t'(value[7:0]) << {lane, 3'b000};
				end
				console_pkg::ppu_bg_tile: tile_we_d = 1'b1;
				console_pkg::ppu_bg_attr: attr_we_d = 1'b1;
				// Unknown codes drop the command
				default: ;
			endcase
		end
	end

	////////////////////////////////
	// Request registers
	////////////////////////////////

	// Enables
	always_ff @(posedge clk_100mhz_buf) begin
		if (rst) begin
			oam_we_q  <= 4'b0000;
			tile_we_q <= 1'b0;
			attr_we_q <= 1'b0;
		end else begin
			oam_we_q  <= oam_we_d;
			tile_we_q <= tile_we_d;
			attr_we_q <= attr_we_d;
		end
	end

	// Address and data, qualified by the enables
	always_ff @(posedge clk_100mhz_buf) begin
		oam_addr_q <= index[5:0];
		oam_data_q <= oam_data_d;
		bg_addr_q  <= index;
		bg_data_q  <= value[7:0];
	end

	assign oam_wr = '{we: oam_we_q, addr: oam_addr_q, data: oam_data_q};
	assign bg_wr  = '{tile_we: tile_we_q, attr_we: attr_we_q, addr: bg_addr_q, data: bg_data_q};

endmodule

// ==== design/scan_timing.sv ====
`timescale 1ns/100ps

module scan_timing #(
	parameter int PIX_DIV  = 4,
	parameter int H_ACTIVE = 640,
	parameter int H_FRONT  = 16,
	parameter int H_SYNC   = 96,
	parameter int H_BACK   = 48,
	parameter int V_ACTIVE = 480,
	parameter int V_FRONT  = 10,
	parameter int V_SYNC   = 2,
	parameter int V_BACK   = 33
) (
	input  logic                   clk_100mhz_buf,
	input  logic                   rst,
	output console_pkg::scan_pos_t scan
);

	// Window edges in counter units
	localparam int H_SYNC_START = H_ACTIVE + H_FRONT;
	localparam int H_SYNC_END   = H_SYNC_START + H_SYNC;
	localparam int H_TOTAL      = H_SYNC_END + H_BACK;
	localparam int V_SYNC_START = V_ACTIVE + V_FRONT;
	localparam int V_SYNC_END   = V_SYNC_START + V_SYNC;
	localparam int V_TOTAL      = V_SYNC_END + V_BACK;
	localparam int DIV_W        = $clog2(PIX_DIV + 1);

	logic [DIV_W-1:0]       div_cnt;
	logic                   pix_en;
	logic [9:0]             h_cnt;
	logic [9:0]             v_cnt;
	console_pkg::scan_pos_t scan_d;

	////////////////////////////////
	// Pixel enable
	////////////////////////////////

	// Stands in for the 25 MHz pixel clock
	assign pix_en = (div_cnt == DIV_W'(PIX_DIV - 1));

	always_ff @(posedge clk_100mhz_buf) begin
		if (rst || pix_en) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// Line and frame counters, wrap at the totals
	always_ff @(posedge clk_100mhz_buf) begin
		if (rst) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (pix_en) begin
			if (h_cnt == 10'(H_TOTAL - 1)) begin
				h_cnt <= '0;
				v_cnt <= (v_cnt == 10'(V_TOTAL - 1)) ? 10'd0 : v_cnt + 10'd1;
			end else begin
				h_cnt <= h_cnt + 10'd1;
			end
		end
	end

	////////////////////////////////
	// Sync and blank decode
	////////////////////////////////

	// Syncs active low, blank high off the visible area
	always_comb begin
		scan_d.x     = h_cnt;
		scan_d.y     = v_cnt;
		scan_d.hsync = ~((h_cnt >= H_SYNC_START) && (h_cnt < H_SYNC_END));
		scan_d.vsync = ~((v_cnt >= V_SYNC_START) && (v_cnt < V_SYNC_END));
		scan_d.blank = (h_cnt >= H_ACTIVE) || (v_cnt >= V_ACTIVE);
	end

	// Reset value matches counters at zero
	always_ff @(posedge clk_100mhz_buf) begin
		if (rst) begin
			scan <= '{x: 10'd0, y: 10'd0, hsync: 1'b1, vsync: 1'b1, blank: 1'b0};
		end else begin
			scan <= scan_d;
		end
	end

endmodule

// ==== sources.f ====
design/console_pkg.sv
design/operand_fwd_mux.sv
design/ppu_cmd_ctrl.sv
design/oam_ram.sv
design/bg_map_ram.sv
design/scan_timing.sv
design/frame_tick_status.sv
design/console_top.sv
tests/console_sva.sv
tests/console_tb.sv

// ==== tests/console_stimulus.txt ====
# C en op index value sel1 sel2 [mem_alu wb_alu mem_load] | O addr word | B index tile attr
# L last OAM addr | K key pulse | F frames to watch    (all numbers hex)
C 1 1 005 11223344 0 0
C 1 1 02a a5a5f00f 0 0
O 05 11223344
O 2a a5a5f00f
L 2a
C 1 2 205 000000ee 0 0
C 1 2 305 00000077 0 0
C 0 1 005 00000000 0 0
C 1 9 005 00000000 0 0
O 05 77ee3344
L 05
C 1 3 123 0000005a 0 0
C 1 4 123 000000c3 0 0
C 0 3 123 00000011 0 0
B 123 5a c3
C 1 4 040 00000099 0 0
C 1 3 040 00000066 0 0
B 040 66 99
C 1 1 000 00000000 1 2 0000003c deadbeef 12345678
O 3c deadbeef
C 1 1 011 cafef00d 2 3 00000000 00000017 8badf00d
O 17 8badf00d
C 1 4 2b1 00000042 0 0
C 1 3 000 00000000 3 1 000000a7 00000000 000002b1
B 2b1 a7 42
L 17
K
K
K
F 3
L 17

// ==== tests/console_sva.sv ====
`timescale 1ns/100ps

module console_sva (
	input logic       clk_100mhz_buf,
	input logic       rst,
	// Every registered write enable
	input logic [5:0] we,
	// Tile and attribute enables
	input logic [1:0] bg_we,
	input logic       tick
);

	// Requests stay quiet right out of reset
	we_after_reset: assert property (@(posedge clk_100mhz_buf) rst |=> (we == '0))
		else $error("write enable high in the cycle after reset");

	// Single-cycle frame pulse
	tick_single: assert property (@(posedge clk_100mhz_buf) disable iff (rst)
		tick |=> !tick)
		else $error("frame tick held for two cycles");

	// One background map per request
	bg_we_onehot: assert property (@(posedge clk_100mhz_buf) $onehot0(bg_we))
		else $error("tile and attribute enables high together");

endmodule

bind console_top console_sva console_sva_inst (
	.clk_100mhz_buf(clk_100mhz_buf), .rst(rst),
	.we({oam_wr.we, bg_wr.tile_we, bg_wr.attr_we}),
	.bg_we({bg_wr.tile_we, bg_wr.attr_we}), .tick(frame_tick)
);

// ==== tests/console_tb.sv ====
`timescale 1ns/100ps

module console_tb;

	// Small raster for the run, one pixel per clock
	localparam int H_ACT        = 16;
	localparam int H_FP         = 2;
	localparam int H_SW         = 2;
	localparam int H_BP         = 2;
	localparam int V_ACT        = 8;
	localparam int V_FP         = 1;
	localparam int V_SW         = 1;
	localparam int V_BP         = 1;
	localparam int LINE_CYCLES  = H_ACT + H_FP + H_SW + H_BP;
	localparam int FRAME_LINES  = V_ACT + V_FP + V_SW + V_BP;
	localparam int FRAME_CYCLES = LINE_CYCLES * FRAME_LINES;

	logic                      clk_100mhz_buf;
	logic                      rst;
	console_pkg::cpu_ppu_cmd_t cmd;
	console_pkg::fwd_bus_t     fwd;
	logic                      keyboard_intr;
	logic [5:0]                oam_rd_addr;
	console_pkg::index_t       bg_rd_addr;
	console_pkg::word_t        oam_rd_data;
	console_pkg::byte_t        bg_tile_rd_data;
	console_pkg::byte_t        bg_attr_rd_data;
	console_pkg::scan_pos_t    scan;
	logic                      frame_tick;
	console_pkg::led_t         leds;

	// Run bookkeeping
	int    errors = 0;
	int    cycles = 0;
	int    cycle_limit = 0;
	// Frame events since reset
	int    tick_count = 0;
	int    vsync_falls = 0;
	logic  vsync_prev = 1'b1;
	int    key_count = 0;
	string records[$];
	// Raster reference
	int                     raster_n = 0;
	console_pkg::scan_pos_t scan_exp;

	console_top #(
		.PIX_DIV(1), .H_ACTIVE(H_ACT), .H_FRONT(H_FP), .H_SYNC(H_SW), .H_BACK(H_BP),
		.V_ACTIVE(V_ACT), .V_FRONT(V_FP), .V_SYNC(V_SW), .V_BACK(V_BP)
	) console_top_inst (.*);

	initial begin
		clk_100mhz_buf = 1'b0;
		forever #5 clk_100mhz_buf = ~clk_100mhz_buf;
	end

	//////////////////////////////
	// Monitors
	//////////////////////////////

	// Clocks since reset release
	always @(posedge clk_100mhz_buf) begin
		if (rst)
			raster_n <= 0;
		else
			raster_n <= raster_n + 1;
	end

	// Raster check each cycle, totals move after the edge
	always @(negedge clk_100mhz_buf) begin
		scan_exp = expected_scan(raster_n);
		check_scan(scan, scan_exp, "scan position");
		vsync_prev <= scan_exp.vsync;
		if (vsync_prev && !scan_exp.vsync) vsync_falls <= vsync_falls + 1;
		if (frame_tick) tick_count <= tick_count + 1;
	end

	// Watchdog
	always @(posedge clk_100mhz_buf) begin
		cycles <= cycles + 1;
		if (cycle_limit != 0 && cycles >= cycle_limit) begin
			$display("Timeout: test still running after %0d cycles", cycles);
			$display("Test failed");
			$finish;
		end
	end

	//////////////////////////////
	// Raster reference
	//////////////////////////////

	// Position held by the scan register, one clock behind the count
	function automatic console_pkg::scan_pos_t expected_scan(input int n);
		console_pkg::scan_pos_t s;
		int p;
		int px;
		int py;
		p  = (n == 0) ? 0 : n - 1;
		px = p % LINE_CYCLES;
		py = (p / LINE_CYCLES) % FRAME_LINES;
		s.x     = 10'(px);
		s.y     = 10'(py);
		// Syncs low inside their windows
		s.hsync = !(px >= H_ACT + H_FP && px < H_ACT + H_FP + H_SW);
		s.vsync = !(py >= V_ACT + V_FP && py < V_ACT + V_FP + V_SW);
		s.blank = (px >= H_ACT) || (py >= V_ACT);
		return s;
	endfunction

	//////////////////////////////
	// Compare tasks
	//////////////////////////////

	task automatic check_word(input console_pkg::word_t got, input console_pkg::word_t exp,
			input string what);
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_byte(input console_pkg::byte_t got, input console_pkg::byte_t exp,
			input string what);
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_leds(input console_pkg::led_t got, input console_pkg::led_t exp,
			input string what);
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_scan(input console_pkg::scan_pos_t got,
			input console_pkg::scan_pos_t exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: %s got x=%0d y=%0d h=%b v=%b b=%b",
				$time, what, got.x, got.y, got.hsync, got.vsync, got.blank);
			$display("    expected x=%0d y=%0d h=%b v=%b b=%b",
				exp.x, exp.y, exp.hsync, exp.vsync, exp.blank);
		end
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		if (got != exp) begin
			errors++;
			$display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	//////////////////////////////
	// Record player
	//////////////////////////////

	task automatic idle_inputs();
		cmd.en        = 1'b0;
		keyboard_intr = 1'b0;
	endtask

	// Starts and ends on a falling edge
	task automatic run_record(input string line);
		string       kind;
		int          n;
		int          target;
		logic [31:0] v [9];
		n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h", kind,
			v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8]);
		case (kind)
			"C": begin
				cmd.en          = v[0][0];
				cmd.opcode      = console_pkg::ppu_op_e'(v[1][3:0]);
				cmd.index       = v[2][9:0];
				cmd.value       = v[3];
				cmd.fwd_src_in1 = console_pkg::fwd_sel_e'(v[4][1:0]);
				cmd.fwd_src_in2 = console_pkg::fwd_sel_e'(v[5][1:0]);
				// Pipeline results from the file, else filler
				if (n == 10)
					fwd = '{mem_alu: v[6], wb_alu: v[7], mem_load: v[8]};
				else
					fwd = '{mem_alu: $urandom(), wb_alu: $urandom(), mem_load: $urandom()};
				@(negedge clk_100mhz_buf);
			end
			"O": begin
				idle_inputs();
				oam_rd_addr = v[0][5:0];
				// Address sampled once too early, then fresh
				repeat (2) @(negedge clk_100mhz_buf);
				check_word(oam_rd_data, v[1], $sformatf("OAM word %h", v[0][5:0]));
			end
			"B": begin
				idle_inputs();
				bg_rd_addr = v[0][9:0];
				repeat (2) @(negedge clk_100mhz_buf);
				check_byte(bg_tile_rd_data, v[1][7:0], $sformatf("tile map %h", v[0][9:0]));
				check_byte(bg_attr_rd_data, v[2][7:0], $sformatf("attr map %h", v[0][9:0]));
			end
			"L": begin
				idle_inputs();
				// Slot from the file, heartbeats from the event counts
				check_leds(leds, {v[0][5:0], key_count[0], tick_count[0]}, "LED state");
			end
			"K": begin
				cmd.en        = 1'b0;
				keyboard_intr = 1'b1;
				@(negedge clk_100mhz_buf);
				keyboard_intr = 1'b0;
				key_count++;
			end
			"F": begin
				idle_inputs();
				target = vsync_falls + int'(v[0]);
				while (vsync_falls < target) @(negedge clk_100mhz_buf);
				check_count(tick_count, vsync_falls, "frame ticks vs vsync falls");
			end
			default: begin
				errors++;
				$display("Unknown record kind '%s' in stimulus file", kind);
			end
		endcase
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial begin
		int    fd;
		string line;
		void'($urandom(49));
		rst           = 1'b1;
		cmd           = '0;
		fwd           = '0;
		keyboard_intr = 1'b0;
		oam_rd_addr   = '0;
		bg_rd_addr    = '0;
		fd = $fopen("tests/console_stimulus.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("Could not open the stimulus file tests/console_stimulus.txt");
		end else begin
			// Skip comment and blank lines
			while ($fgets(line, fd)) begin
				if (line.len() > 1 && line[0] != "#") records.push_back(line);
			end
			$fclose(fd);
		end
		cycle_limit = records.size() * 8 + 4 * FRAME_CYCLES;
		repeat (3) @(posedge clk_100mhz_buf);
		@(negedge clk_100mhz_buf);
		rst = 1'b0;
		@(negedge clk_100mhz_buf);
		check_leds(leds, '0, "LEDs after reset");
		check_flag(frame_tick, 1'b0, "frame tick after reset");
		foreach (records[k]) run_record(records[k]);
		idle_inputs();
		$display("Checks done, errors: %0d", errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule
